// ==== include/mshr_params.svh ====
`ifndef MSHR_PARAMS_SVH
`define MSHR_PARAMS_SVH

// ========================================
// MSHR sizing
// ========================================

// number of outstanding miss entries
`define MSHR_ENTRY_NUM   4

// cache address fields
`define MSHR_INDEX_W     6
`define MSHR_TAG_W       12

// way select into the data RAM
`define MSHR_WAY_W       2

// data RAM beats needed to read out one victim line
`define MSHR_EVICT_BEATS 4

`endif

// ==== hw/mshr_pkg.sv ====
`default_nettype none

`include "mshr_params.svh"

package mshr_pkg;

    // data RAM operation codes
    typedef enum logic [1:0] {
        READ  = 2'd0,
        WRITE = 2'd1,
        EVICT = 2'd2
    } mshr_op_e;

    typedef logic [$clog2(`MSHR_ENTRY_NUM)-1:0]   entry_id_t;
    typedef logic [$clog2(`MSHR_EVICT_BEATS)-1:0] beat_t;

    // request accepted from the cache pipeline, op is READ or WRITE
    typedef struct packed {
        mshr_op_e                 op;
        logic [`MSHR_INDEX_W-1:0] index;
        logic [`MSHR_TAG_W-1:0]   tag;
        logic [`MSHR_TAG_W-1:0]   victim_tag;
        logic [`MSHR_WAY_W-1:0]   way;
        logic                     need_evict;
        logic                     need_linefill;
    } mshr_req_t;

    // data RAM request, tag carries the victim tag on EVICT beats
    typedef struct packed {
        mshr_op_e                 op;
        entry_id_t                entry_id;
        logic [`MSHR_INDEX_W-1:0] index;
        logic [`MSHR_WAY_W-1:0]   way;
        logic [`MSHR_TAG_W-1:0]   tag;
        beat_t                    beat;
        logic                     last;
    } ram_req_t;

    // downstream linefill request
    typedef struct packed {
        entry_id_t                entry_id;
        logic [`MSHR_TAG_W-1:0]   tag;
        logic [`MSHR_INDEX_W-1:0] index;
        logic [`MSHR_WAY_W-1:0]   way;
    } ds_req_t;

endpackage

`default_nettype wire

// ==== hw/mshr_rr_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_rr_arb #(
    parameter int N      = 4,
    parameter type PLD_T = logic
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [N-1:0] in_vld,
    output logic [N-1:0] in_rdy,
    input  PLD_T         in_pld [N],
    output logic         out_vld,
    input  logic         out_rdy,
    output PLD_T         out_pld
);
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] rr_idx;
    logic [IDX_W-1:0] gnt_idx;
    logic [IDX_W-1:0] lock_idx;
    logic             rr_found;
    logic             lock;

    // first valid requester at or after the pointer
    always_comb begin
        rr_found = 1'b0;
        rr_idx   = ptr;
        for (int k = 0; k < N; k++) begin
            if (!rr_found && in_vld[(int'(ptr) + k) % N]) begin
                rr_found = 1'b1;
                rr_idx   = IDX_W'((int'(ptr) + k) % N);
            end
        end
    end

    // stalled grant is held, its requester keeps valid high
    assign gnt_idx = lock ? lock_idx : rr_idx;
    assign out_vld = |in_vld;
    assign out_pld = in_pld[gnt_idx];

    always_comb begin
        for (int i = 0; i < N; i++) begin
            in_rdy[i] = out_vld && out_rdy && (gnt_idx == IDX_W'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock     <= 1'b0;
            lock_idx <= '0;
        end else if (out_vld && !out_rdy) begin
            lock     <= 1'b1;
            lock_idx <= gnt_idx;
        end else if (out_vld && out_rdy) begin
            lock     <= 1'b0;
        end
    end

    // pointer moves past the winner on each transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (out_vld && out_rdy) begin
            ptr <= IDX_W'((int'(gnt_idx) + 1) % N);
        end
    end

endmodule

`default_nettype wire

// ==== hw/mshr_alloc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_params.svh"

module mshr_alloc_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_vld,
    output logic                          req_rdy,
    input  mshr_pkg::mshr_req_t           req_pld,
    input  logic [`MSHR_ENTRY_NUM-1:0]    busy,
    input  logic [`MSHR_INDEX_W-1:0]      entry_index [`MSHR_ENTRY_NUM],
    input  logic [`MSHR_ENTRY_NUM-1:0]    release_vec,
    output logic [`MSHR_ENTRY_NUM-1:0]    alloc_en,
    output logic [`MSHR_ENTRY_NUM-1:0]    alloc_hzd_bitmap,
    output logic                          release_vld,
    output mshr_pkg::entry_id_t           release_id
);
    import mshr_pkg::*;

    logic      free_found;
    entry_id_t free_id;
    entry_id_t rel_id_nxt;

    // ========================================
    // allocation
    // ========================================

    assign req_rdy = ~&busy;

    // lowest numbered free entry wins
    always_comb begin
        free_found = 1'b0;
        free_id    = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (!free_found && !busy[i]) begin
                free_found = 1'b1;
                free_id    = entry_id_t'(i);
            end
        end
    end

    always_comb begin
        alloc_en = '0;
        if (req_vld && req_rdy) begin
            alloc_en[free_id] = 1'b1;
        end
    end

    // older entries on the same set, minus the one leaving this cycle
    always_comb begin
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            alloc_hzd_bitmap[i] = busy[i] && !release_vec[i] &&
                                  (entry_index[i] == req_pld.index);
        end
    end

    // ========================================
    // release encoding
    // ========================================

    // at most one entry releases per cycle since ram_done is addressed
    always_comb begin
        rel_id_nxt = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (release_vec[i]) begin
                rel_id_nxt = entry_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            release_vld <= 1'b0;
            release_id  <= '0;
        end else begin
            release_vld <= |release_vec;
            release_id  <= rel_id_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mshr_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_params.svh"

module mshr_entry #(
    parameter int unsigned ENTRY_ID = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          alloc_en,
    input  mshr_pkg::mshr_req_t           alloc_req,
    input  logic [`MSHR_ENTRY_NUM-1:0]    alloc_hzd_bitmap,
    input  logic [`MSHR_ENTRY_NUM-1:0]    release_vec,
    input  logic                          linefill_done,
    input  mshr_pkg::entry_id_t           linefill_done_id,
    input  logic                          ram_done,
    input  mshr_pkg::entry_id_t           ram_done_id,
    output logic                          busy,
    output logic [`MSHR_INDEX_W-1:0]      entry_index,
    output logic                          ram_req_vld,
    input  logic                          ram_req_rdy,
    output mshr_pkg::ram_req_t            ram_req_pld,
    output logic                          ds_req_vld,
    input  logic                          ds_req_rdy,
    output mshr_pkg::ds_req_t             ds_req_pld,
    output logic                          release_en
);
    import mshr_pkg::*;

    localparam entry_id_t MY_ID     = entry_id_t'(ENTRY_ID);
    localparam beat_t     LAST_BEAT = beat_t'(`MSHR_EVICT_BEATS - 1);

    mshr_req_t                   req_q;
    logic [`MSHR_ENTRY_NUM-1:0]  hzd_bitmap;
    logic                        hazard_free;
    logic                        evict_pend;
    beat_t                       beat_cnt;
    logic                        ds_pend;
    logic                        lf_wait;
    logic                        rw_pend;
    logic                        need_fill;
    logic                        ram_hs;
    logic                        ds_hs;

    assign need_fill = alloc_req.need_evict || alloc_req.need_linefill;
    assign ram_hs    = ram_req_vld && ram_req_rdy;
    assign ds_hs     = ds_req_vld && ds_req_rdy;

    // request captured at allocation
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            req_q <= alloc_req;
        end
    end

    assign entry_index = req_q.index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (alloc_en) begin
            busy <= 1'b1;
        end else if (release_en) begin
            busy <= 1'b0;
        end
    end

    // ========================================
    // hazard wait
    // ========================================

    // drops older same-index entries as they leave
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hzd_bitmap <= '0;
        end else if (alloc_en) begin
            hzd_bitmap <= alloc_hzd_bitmap;
        end else begin
            hzd_bitmap <= hzd_bitmap & ~release_vec;
        end
    end

    // stays set until this entry releases
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hazard_free <= 1'b0;
        end else if (alloc_en || release_en) begin
            hazard_free <= 1'b0;
        end else if (busy && ((hzd_bitmap & ~release_vec) == '0)) begin
            hazard_free <= 1'b1;
        end
    end

    // ========================================
    // progress flags
    // ========================================

    // evict beats go first on the RAM bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evict_pend <= 1'b0;
            beat_cnt   <= '0;
        end else if (alloc_en) begin
            evict_pend <= alloc_req.need_evict;
            beat_cnt   <= '0;
        end else if (ram_hs && evict_pend) begin
            evict_pend <= (beat_cnt != LAST_BEAT);
            beat_cnt   <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_pend <= 1'b0;
        end else if (alloc_en) begin
            ds_pend <= need_fill;
        end else if (ds_hs) begin
            ds_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lf_wait <= 1'b0;
        end else if (alloc_en) begin
            lf_wait <= need_fill;
        end else if (linefill_done && (linefill_done_id == MY_ID) && !ds_pend) begin
            lf_wait <= 1'b0;
        end
    end

    // the read or write itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rw_pend <= 1'b0;
        end else if (alloc_en) begin
            rw_pend <= 1'b1;
        end else if (ram_hs && !evict_pend) begin
            rw_pend <= 1'b0;
        end
    end

    // ram_done addressed here closes the transaction
    assign release_en = busy && !rw_pend && ram_done && (ram_done_id == MY_ID);

    // ========================================
    // request generation
    // ========================================

    assign ram_req_vld = hazard_free &&
                         (evict_pend || (rw_pend && !ds_pend && !lf_wait));

    always_comb begin
        ram_req_pld          = '0;
        ram_req_pld.entry_id = MY_ID;
        ram_req_pld.index    = req_q.index;
        ram_req_pld.way      = req_q.way;
        if (evict_pend) begin
            ram_req_pld.op   = EVICT;
            ram_req_pld.tag  = req_q.victim_tag;
            ram_req_pld.beat = beat_cnt;
            ram_req_pld.last = (beat_cnt == LAST_BEAT);
        end else begin
            ram_req_pld.op   = req_q.op;
            ram_req_pld.tag  = req_q.tag;
            ram_req_pld.beat = '0;
            ram_req_pld.last = 1'b1;
        end
    end

    // linefill waits for the last evict beat to be taken
    assign ds_req_vld = hazard_free && ds_pend && !evict_pend;

    assign ds_req_pld.entry_id = MY_ID;
    assign ds_req_pld.tag      = req_q.tag;
    assign ds_req_pld.index    = req_q.index;
    assign ds_req_pld.way      = req_q.way;

endmodule

`default_nettype wire

// ==== hw/mshr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_params.svh"

module mshr_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // request in
    input  logic                  req_vld,
    output logic                  req_rdy,
    input  mshr_pkg::mshr_req_t   req_pld,
    // data RAM
    output logic                  ram_req_vld,
    input  logic                  ram_req_rdy,
    output mshr_pkg::ram_req_t    ram_req_pld,
    // downstream linefill
    output logic                  ds_req_vld,
    input  logic                  ds_req_rdy,
    output mshr_pkg::ds_req_t     ds_req_pld,
    // completion pulses
    input  logic                  linefill_done,
    input  mshr_pkg::entry_id_t   linefill_done_id,
    input  logic                  ram_done,
    input  mshr_pkg::entry_id_t   ram_done_id,
    output logic                  release_vld,
    output mshr_pkg::entry_id_t   release_id
);
    import mshr_pkg::*;

    logic [`MSHR_ENTRY_NUM-1:0] busy;
    logic [`MSHR_ENTRY_NUM-1:0] release_vec;
    logic [`MSHR_ENTRY_NUM-1:0] alloc_en;
    logic [`MSHR_ENTRY_NUM-1:0] alloc_hzd_bitmap;
    logic [`MSHR_INDEX_W-1:0]   entry_index [`MSHR_ENTRY_NUM];

    logic [`MSHR_ENTRY_NUM-1:0] ent_ram_vld;
    logic [`MSHR_ENTRY_NUM-1:0] ent_ram_rdy;
    ram_req_t                   ent_ram_pld [`MSHR_ENTRY_NUM];
    logic [`MSHR_ENTRY_NUM-1:0] ent_ds_vld;
    logic [`MSHR_ENTRY_NUM-1:0] ent_ds_rdy;
    ds_req_t                    ent_ds_pld [`MSHR_ENTRY_NUM];

    // ========================================
    // allocator
    // ========================================

    mshr_alloc_ctrl u_alloc_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_vld          (req_vld),
        .req_rdy          (req_rdy),
        .req_pld          (req_pld),
        .busy             (busy),
        .entry_index      (entry_index),
        .release_vec      (release_vec),
        .alloc_en         (alloc_en),
        .alloc_hzd_bitmap (alloc_hzd_bitmap),
        .release_vld      (release_vld),
        .release_id       (release_id)
    );

    // ========================================
    // entries
    // ========================================

    for (genvar g = 0; g < `MSHR_ENTRY_NUM; g++) begin : g_entry
        mshr_entry #(
            .ENTRY_ID (g)
        ) u_entry (
            .clk              (clk),
            .rst_n            (rst_n),
            .alloc_en         (alloc_en[g]),
            .alloc_req        (req_pld),
            .alloc_hzd_bitmap (alloc_hzd_bitmap),
            .release_vec      (release_vec),
            .linefill_done    (linefill_done),
            .linefill_done_id (linefill_done_id),
            .ram_done         (ram_done),
            .ram_done_id      (ram_done_id),
            .busy             (busy[g]),
            .entry_index      (entry_index[g]),
            .ram_req_vld      (ent_ram_vld[g]),
            .ram_req_rdy      (ent_ram_rdy[g]),
            .ram_req_pld      (ent_ram_pld[g]),
            .ds_req_vld       (ent_ds_vld[g]),
            .ds_req_rdy       (ent_ds_rdy[g]),
            .ds_req_pld       (ent_ds_pld[g]),
            .release_en       (release_vec[g])
        );
    end

    // ========================================
    // shared bus arbiters
    // ========================================

    mshr_rr_arb #(
        .N     (`MSHR_ENTRY_NUM),
        .PLD_T (ram_req_t)
    ) u_ram_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vld  (ent_ram_vld),
        .in_rdy  (ent_ram_rdy),
        .in_pld  (ent_ram_pld),
        .out_vld (ram_req_vld),
        .out_rdy (ram_req_rdy),
        .out_pld (ram_req_pld)
    );

    mshr_rr_arb #(
        .N     (`MSHR_ENTRY_NUM),
        .PLD_T (ds_req_t)
    ) u_ds_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vld  (ent_ds_vld),
        .in_rdy  (ent_ds_rdy),
        .in_pld  (ent_ds_pld),
        .out_vld (ds_req_vld),
        .out_rdy (ds_req_rdy),
        .out_pld (ds_req_pld)
    );

endmodule

`default_nettype wire

// ==== tests/mshr_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_params.svh"

module mshr_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        req_vld,
    input logic                        req_rdy,
    input mshr_pkg::mshr_req_t         req_pld,
    input logic                        ram_req_vld,
    input logic                        ram_req_rdy,
    input mshr_pkg::ram_req_t          ram_req_pld,
    input logic                        ds_req_vld,
    input logic                        ds_req_rdy,
    input mshr_pkg::ds_req_t           ds_req_pld,
    input logic [`MSHR_ENTRY_NUM-1:0]  busy,
    input logic                        release_vld,
    input mshr_pkg::entry_id_t         release_id
);
    // read back by the testbench at the end of the run
    int unsigned fail_cnt;

    initial fail_cnt = 0;

    // ========================================
    // valid/ready stability
    // ========================================

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_vld && !req_rdy |=> req_vld && $stable(req_pld))
    else begin
        fail_cnt++;
        $error("incoming request dropped or changed while stalled");
    end

    ram_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ram_req_vld && !ram_req_rdy |=> ram_req_vld && $stable(ram_req_pld))
    else begin
        fail_cnt++;
        $error("data RAM request dropped or changed while stalled");
    end

    ds_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_req_rdy |=> ds_req_vld && $stable(ds_req_pld))
    else begin
        fail_cnt++;
        $error("downstream request dropped or changed while stalled");
    end

    // ========================================
    // allocation and release
    // ========================================

    // a full MSHR opens up only through a release
    full_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        &busy |=> !req_rdy || release_vld)
    else begin
        fail_cnt++;
        $error("req_rdy rose on a full MSHR without a release");
    end

    // a transaction is far longer than one cycle
    no_double_release: assert property (@(posedge clk) disable iff (!rst_n)
        release_vld |=> !(release_vld && release_id == $past(release_id)))
    else begin
        fail_cnt++;
        $error("release pulsed twice in a row for one entry");
    end

endmodule

bind mshr_top mshr_properties u_props (.*);

`default_nettype wire

// ==== tests/mshr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_params.svh"

module mshr_tb;
    import mshr_pkg::*;

    localparam int N       = `MSHR_ENTRY_NUM;
    localparam int MAX_REQ = 64;

    logic      clk;
    logic      rst_n;
    logic      req_vld;
    logic      req_rdy;
    mshr_req_t req_pld;
    logic      ram_req_vld;
    logic      ram_req_rdy;
    ram_req_t  ram_req_pld;
    logic      ds_req_vld;
    logic      ds_req_rdy;
    ds_req_t   ds_req_pld;
    logic      linefill_done;
    entry_id_t linefill_done_id;
    logic      ram_done;
    entry_id_t ram_done_id;
    logic      release_vld;
    entry_id_t release_id;

    // trace contents
    mshr_req_t trace_req [MAX_REQ];
    int        n_req;
    int        stall_pct;
    bit        trace_loaded;

    // reference model, one slot per entry
    mshr_req_t    ent_req  [N];
    bit           ent_busy [N];
    bit           lf_back  [N];
    int           ram_cnt  [N];
    int           ds_cnt   [N];
    logic [N-1:0] ent_hzd  [N];

    // pending done pulses, due cycle and entry
    int        lf_due [$];
    entry_id_t lf_id  [$];
    int        rd_due [$];
    entry_id_t rd_id  [$];

    // release pulses owed for ram_done already sent
    int        rel_due [$];
    entry_id_t rel_id  [$];

    int errors;
    int sent;
    int released;
    int cyc;
    int seed;

    mshr_top mshr_top_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_vld          (req_vld),
        .req_rdy          (req_rdy),
        .req_pld          (req_pld),
        .ram_req_vld      (ram_req_vld),
        .ram_req_rdy      (ram_req_rdy),
        .ram_req_pld      (ram_req_pld),
        .ds_req_vld       (ds_req_vld),
        .ds_req_rdy       (ds_req_rdy),
        .ds_req_pld       (ds_req_pld),
        .linefill_done    (linefill_done),
        .linefill_done_id (linefill_done_id),
        .ram_done         (ram_done),
        .ram_done_id      (ram_done_id),
        .release_vld      (release_vld),
        .release_id       (release_id)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // expected values
    // ========================================

    function automatic bit need_fill(mshr_req_t r);
        return r.need_evict || r.need_linefill;
    endfunction

    function automatic int ram_beats(mshr_req_t r);
        return (r.need_evict ? `MSHR_EVICT_BEATS : 0) + 1;
    endfunction

    // step counts the RAM requests this entry has already issued
    function automatic ram_req_t expected_ram(mshr_req_t r, entry_id_t id, int step);
        ram_req_t p;
        p          = '0;
        p.entry_id = id;
        p.index    = r.index;
        p.way      = r.way;
        if (r.need_evict && step < `MSHR_EVICT_BEATS) begin
            p.op   = EVICT;
            p.tag  = r.victim_tag;
            p.beat = beat_t'(step);
            p.last = (step == `MSHR_EVICT_BEATS - 1);
        end else begin
            p.op   = r.op;
            p.tag  = r.tag;
            p.last = 1'b1;
        end
        return p;
    endfunction

    function automatic ds_req_t expected_ds(mshr_req_t r, entry_id_t id);
        ds_req_t p;
        p.entry_id = id;
        p.tag      = r.tag;
        p.index    = r.index;
        p.way      = r.way;
        return p;
    endfunction

    function automatic int busy_count();
        int n;
        n = 0;
        for (int e = 0; e < N; e++) begin
            n += ent_busy[e];
        end
        return n;
    endfunction

    function automatic entry_id_t lowest_free();
        for (int e = 0; e < N; e++) begin
            if (!ent_busy[e]) begin
                return entry_id_t'(e);
            end
        end
        return '0;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
        $display("** Error %s: expected %h, got %h (cycle %0d)", name, exp, got, cyc);
        errors++;
    endtask

    task automatic report_problem(string msg);
        $display("cycle %0d: %s", cyc, msg);
        errors++;
    endtask

    // ========================================
    // trace reader
    // ========================================

    task automatic load_trace();
        int        fd;
        int        code;
        int        v [7];
        bit        have_pct;
        string     line;
        mshr_req_t r;
        have_pct = 1'b0;
        fd = $fopen("tests/mshr_trace.txt", "r");
        if (fd == 0) begin
            report_problem("could not open tests/mshr_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (!have_pct) begin
                code     = $sscanf(line, "%d", stall_pct);
                have_pct = 1'b1;
            end else if (n_req < MAX_REQ) begin
                code = $sscanf(line, "%h %h %h %h %h %h %h",
                               v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                if (code != 7) begin
                    report_problem({"malformed trace line: ", line});
                    continue;
                end
                r.op            = mshr_op_e'(v[0][1:0]);
                r.index         = v[1][`MSHR_INDEX_W-1:0];
                r.tag           = v[2][`MSHR_TAG_W-1:0];
                r.victim_tag    = v[3][`MSHR_TAG_W-1:0];
                r.way           = v[4][`MSHR_WAY_W-1:0];
                r.need_evict    = v[5][0];
                r.need_linefill = v[6][0];
                trace_req[n_req] = r;
                n_req++;
            end
        end
        $fclose(fd);
    endtask

    // ========================================
    // monitors and model updates
    // ========================================

    task automatic check_idle();
        if (req_rdy !== 1'b1) report_mismatch("req_rdy", 1, req_rdy);
        if (ram_req_vld !== 1'b0) report_mismatch("ram_req_vld", 0, ram_req_vld);
        if (ds_req_vld !== 1'b0) report_mismatch("ds_req_vld", 0, ds_req_vld);
        if (release_vld !== 1'b0) report_mismatch("release_vld", 0, release_vld);
    endtask

    // release_vld follows each ram_done by one cycle
    task automatic take_release();
        entry_id_t id;
        if (rel_due.size() == 0 || rel_due[0] != cyc) begin
            if (release_vld !== 1'b0)
                report_problem($sformatf("release for entry %0d with no ram_done", release_id));
            return;
        end
        id = rel_id.pop_front();
        void'(rel_due.pop_front());
        if (release_vld !== 1'b1) report_mismatch("release_vld", 1, release_vld);
        else if (release_id !== id) report_mismatch("release_id", id, release_id);
        if (ram_cnt[id] != ram_beats(ent_req[id]) || ds_cnt[id] != int'(need_fill(ent_req[id])))
            report_problem($sformatf("entry %0d released before all its requests", id));
        ent_busy[id] = 1'b0;
        released++;
        for (int e = 0; e < N; e++) begin
            ent_hzd[e][id] = 1'b0;
        end
    endtask

    task automatic take_ram_req();
        entry_id_t id;
        ram_req_t  exp;
        id = ram_req_pld.entry_id;
        if (!ent_busy[id] || ram_cnt[id] >= ram_beats(ent_req[id])) begin
            report_problem($sformatf("unpredicted data RAM request from entry %0d", id));
            return;
        end
        if (ent_hzd[id] != '0)
            report_problem($sformatf("entry %0d used the RAM bus ahead of an older entry", id));
        exp = expected_ram(ent_req[id], id, ram_cnt[id]);
        if (exp.op != EVICT && need_fill(ent_req[id]) && !lf_back[id])
            report_problem($sformatf("entry %0d read or wrote before its linefill", id));
        if (ram_req_pld !== exp) report_mismatch("ram_req_pld", exp, ram_req_pld);
        ram_cnt[id]++;
        if (exp.op != EVICT) begin
            rd_due.push_back(cyc + 3);
            rd_id.push_back(id);
        end
    endtask

    task automatic take_ds_req();
        entry_id_t id;
        ds_req_t   exp;
        id = ds_req_pld.entry_id;
        if (!ent_busy[id] || !need_fill(ent_req[id]) || ds_cnt[id] != 0) begin
            report_problem($sformatf("unpredicted downstream request from entry %0d", id));
            return;
        end
        if (ent_hzd[id] != '0)
            report_problem($sformatf("entry %0d went downstream ahead of an older entry", id));
        if (ent_req[id].need_evict && ram_cnt[id] < `MSHR_EVICT_BEATS)
            report_problem($sformatf("entry %0d linefill before its last evict beat", id));
        exp = expected_ds(ent_req[id], id);
        if (ds_req_pld !== exp) report_mismatch("ds_req_pld", exp, ds_req_pld);
        ds_cnt[id]++;
        lf_due.push_back(cyc + 5);
        lf_id.push_back(id);
    endtask

    task automatic take_alloc();
        entry_id_t id;
        id = lowest_free();
        for (int e = 0; e < N; e++) begin
            ent_hzd[id][e] = ent_busy[e] && (ent_req[e].index == req_pld.index);
        end
        ent_req[id]  = req_pld;
        ent_busy[id] = 1'b1;
        lf_back[id]  = 1'b0;
        ram_cnt[id]  = 0;
        ds_cnt[id]   = 0;
        sent++;
    endtask

    // ========================================
    // stimulus and responders
    // ========================================

    task automatic drive_inputs();
        req_vld     <= (sent < n_req);
        req_pld     <= trace_req[(sent < n_req) ? sent : 0];
        ram_req_rdy <= ({$random(seed)} % 100) >= stall_pct;
        ds_req_rdy  <= ({$random(seed)} % 100) >= stall_pct;
        linefill_done <= 1'b0;
        ram_done      <= 1'b0;
        if (lf_due.size() > 0 && lf_due[0] <= cyc) begin
            linefill_done    <= 1'b1;
            linefill_done_id <= lf_id[0];
            lf_back[lf_id[0]] = 1'b1;
            void'(lf_due.pop_front());
            void'(lf_id.pop_front());
        end
        if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
            ram_done    <= 1'b1;
            ram_done_id <= rd_id[0];
            // sampled by the DUT next edge, release seen one edge later
            rel_due.push_back(cyc + 2);
            rel_id.push_back(rd_id[0]);
            void'(rd_due.pop_front());
            void'(rd_id.pop_front());
        end
    endtask

    // release is taken before allocation, a freed slot is reusable at once
    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            if (sent == 0) check_idle();
            take_release();
            if (ram_req_vld && ram_req_rdy) take_ram_req();
            if (ds_req_vld && ds_req_rdy) take_ds_req();
            if (req_rdy !== (busy_count() < N))
                report_mismatch("req_rdy", busy_count() < N, req_rdy);
            if (req_vld && req_rdy) take_alloc();
            drive_inputs();
        end
    end

    initial begin
        rst_n            = 1'b0;
        req_vld          = 1'b0;
        req_pld          = '0;
        ram_req_rdy      = 1'b0;
        ds_req_rdy       = 1'b0;
        linefill_done    = 1'b0;
        linefill_done_id = '0;
        ram_done         = 1'b0;
        ram_done_id      = '0;
        errors           = 0;
        sent             = 0;
        released         = 0;
        cyc              = 0;
        n_req            = 0;
        stall_pct        = 0;
        seed             = 80285;
        for (int e = 0; e < N; e++) begin
            ent_busy[e] = 1'b0;
            ent_hzd[e]  = '0;
        end
        load_trace();
        trace_loaded = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait (released == n_req);
        repeat (20) @(posedge clk);
        errors += mshr_top_inst.u_props.fail_cnt;
        $display("transactions: %0d of %0d, errors: %0d", released, n_req, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, scaled by trace length
    initial begin
        wait (trace_loaded);
        repeat (n_req * 200 + 500) @(posedge clk);
        $display("timeout: only %0d of %0d transactions released after %0d cycles, errors: %0d",
                 released, n_req, n_req * 200 + 500, errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mshr_top.f ====
+incdir+include
hw/mshr_pkg.sv
hw/mshr_rr_arb.sv
hw/mshr_alloc_ctrl.sv
hw/mshr_entry.sv
hw/mshr_top.sv
tests/mshr_properties.sv
tests/mshr_tb.sv

// ==== tests/mshr_trace.txt ====
# first value: percent of cycles with ram_req_rdy or ds_req_rdy held low
# then one request per line, hex: op(0 read, 1 write) index tag victim_tag way need_evict need_linefill
30
0 05 123 000 1 0 1
1 05 124 0a1 2 1 1
0 12 3f0 000 0 0 0
1 12 3f1 000 3 0 0
0 2a 7c2 5b3 1 1 0
1 05 125 124 2 1 0
0 33 001 000 0 0 1
1 07 abc def 3 1 1
0 12 3f2 3f0 0 1 1
0 3f fff 800 3 1 1
1 00 000 000 0 0 0
0 2a 7c3 7c2 1 0 1
1 2a 7c4 000 2 0 0
0 19 456 789 1 1 1
1 19 457 000 1 0 0
0 08 321 000 2 0 1
1 21 0f0 0e0 0 1 0
0 21 0f1 000 0 0 1
1 05 126 125 2 1 1
0 3c 9a9 000 3 0 0
